// ==== filelist.f ====
+incdir+.
raster_pkg.sv
msaa_step_reg.sv
box_walker.sv
iterator_ctrl.sv
test_iterator.sv
tb_test_iterator.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the iterator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_test_iterator -f filelist.f -o tb_test_iterator

./obj_dir/tb_test_iterator > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

// ==== tb_cases.svh ====
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

// Columns: name, ll.x ll.y ur.x ur.y in eighths of a pixel,
// width at accept, width driven after accept, idle cycles, expected samples
task automatic load_cases();
    // Long idle right after reset, plain 1x walk
    add_case("idle_then_1x",     0,   0, 24, 16, 4'b1000, 4'b1000, 6, 12);
    // Box below and left of the origin
    add_case("negative_box_1x", -16, -8,  8,  8, 4'b1000, 4'b1000, 2, 12);
    // Width switched to 64x mid-walk, half pixel steps must hold
    add_case("mid_change_4x",    8,   8, 20, 16, 4'b0100, 4'b0001, 1, 12);
    // Next triangle picks up the 64x width
    add_case("next_uses_64x",    0,   0,  3,  2, 4'b0001, 4'b0001, 1, 12);
    add_case("quarter_16x",     -4,   0,  4,  6, 4'b0010, 4'b1000, 3, 20);
    // Lower-left equals upper-right
    add_case("single_point_1x", 40,  40, 40, 40, 4'b1000, 4'b1000, 1, 1);
    add_case("single_point_64x", 3,   5,  3,  5, 4'b0001, 4'b0001, 0, 1);
    // 16x walk with a change back to 1x
    add_case("mid_change_16x",   2,   2,  6,  4, 4'b0010, 4'b1000, 2, 6);
    // One row only
    add_case("single_row_1x",    0,   0, 40,  0, 4'b1000, 4'b1000, 1, 6);
endtask

`endif

// ==== tb_test_iterator.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_test_iterator
    import raster_pkg::*;
();

    // One stimulus row and its expected sample count
    typedef struct {
        string      name;
        box_t       box;
        subsample_t sub;
        subsample_t sub_after;
        int         idle;
        int         count;
        triangle_t  tri_val;
        color_t     color_val;
    } case_t;

    logic       clk;
    logic       rst;
    triangle_t  tri_in;
    color_t     color_in;
    box_t       box_in;
    logic       valid_in;
    subsample_t subsample;
    triangle_t  tri_out;
    color_t     color_out;
    point_t     sample_out;
    logic       valid_out;
    logic       halt_n;

    case_t cases[$];
    int    seed;
    string cur_name;

    test_iterator uut (
        .clk        (clk),
        .rst        (rst),
        .tri_in     (tri_in),
        .color_in   (color_in),
        .box_in     (box_in),
        .valid_in   (valid_in),
        .subsample  (subsample),
        .tri_out    (tri_out),
        .color_out  (color_out),
        .sample_out (sample_out),
        .valid_out  (valid_out),
        .halt_n     (halt_n)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run();
        $display("CHECKS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_fixed(input string what, input fixed_t expected, input fixed_t actual);
        assert (actual == expected) else begin
            $display("mismatch %s %s: expected %0d actual %0d", cur_name, what, expected, actual);
            fail_run();
        end
    endtask

    task automatic check_tri(input triangle_t expected, input triangle_t actual);
        assert (actual == expected) else begin
            $display("mismatch %s tri_out: expected %h actual %h", cur_name, expected, actual);
            fail_run();
        end
    endtask

    task automatic check_color(input color_t expected, input color_t actual);
        assert (actual == expected) else begin
            $display("mismatch %s color_out: expected %h actual %h", cur_name, expected, actual);
            fail_run();
        end
    endtask

    task automatic check_int(input string what, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("mismatch %s %s: expected %0d actual %0d", cur_name, what, expected, actual);
            fail_run();
        end
    endtask

    task automatic check_true(input bit cond, input string msg);
        assert (cond) else begin
            $display("%s: %s", cur_name, msg);
            fail_run();
        end
    endtask

    task automatic random_triangle(output triangle_t t);
        for (int v = 0; v < VERTS; v++) begin
            t[v].x = fixed_t'($random(seed));
            t[v].y = fixed_t'($random(seed));
            t[v].z = fixed_t'($random(seed));
        end
    endtask

    task automatic random_color(output color_t c);
        for (int k = 0; k < COLORS; k++) begin
            c[k] = ucolor_t'($random(seed));
        end
    endtask

    // Corners given in eighths of a pixel
    function automatic box_t box_from_eighths(input int llx, input int lly,
                                              input int urx, input int ury);
        box_t b;
        b.ll.x = fixed_t'(llx * (1 << (RADIX - 3)));
        b.ll.y = fixed_t'(lly * (1 << (RADIX - 3)));
        b.ur.x = fixed_t'(urx * (1 << (RADIX - 3)));
        b.ur.y = fixed_t'(ury * (1 << (RADIX - 3)));
        return b;
    endfunction

    // 1x one pixel, 4x half, 16x quarter, 64x eighth
    function automatic fixed_t step_of(input subsample_t s);
        case (s)
            4'b1000: return fixed_t'(1 << RADIX);
            4'b0100: return fixed_t'(1 << (RADIX - 1));
            4'b0010: return fixed_t'(1 << (RADIX - 2));
            4'b0001: return fixed_t'(1 << (RADIX - 3));
            default: return fixed_t'(0);
        endcase
    endfunction

    // Columns times rows of an aligned box
    function automatic int count_from_rule(input box_t b, input fixed_t st);
        int cols;
        int rows;
        cols = int'((b.ur.x - b.ll.x) / st) + 1;
        rows = int'((b.ur.y - b.ll.y) / st) + 1;
        return cols * rows;
    endfunction

    task automatic add_case(input string name, input int llx, input int lly,
                            input int urx, input int ury, input subsample_t sub,
                            input subsample_t sub_after, input int idle, input int count);
        case_t c;
        c.name = name;
        c.box = box_from_eighths(llx, lly, urx, ury);
        c.sub = sub;
        c.sub_after = sub_after;
        c.idle = idle;
        c.count = count;
        random_triangle(c.tri_val);
        random_color(c.color_val);
        cases.push_back(c);
    endtask

    `include "tb_cases.svh"

    task automatic wait_for_valid();
        int n;
        n = 0;
        @(negedge clk);
        while (!valid_out && n < 64) begin
            @(negedge clk);
            n++;
        end
        check_true(valid_out, "timeout waiting for valid_out after accept");
    endtask

    task automatic wait_for_halt();
        int n;
        n = 0;
        while (!halt_n && n < 64) begin
            @(negedge clk);
            n++;
        end
        check_true(halt_n, "timeout waiting for halt_n to rise after the walk");
    endtask

    task automatic run_case(input case_t c);
        point_t    exp_s;
        point_t    last_s;
        fixed_t    st;
        int        seen;
        triangle_t junk_tri;
        color_t    junk_color;
        cur_name = c.name;
        st = step_of(c.sub);
        // Outputs stay quiet through the idle gap
        for (int i = 0; i < c.idle; i++) begin
            @(posedge clk);
            valid_in <= 1'b0;
            @(negedge clk);
            check_true(!valid_out && halt_n, "outputs not idle while valid_in is low");
        end
        @(posedge clk);
        tri_in <= c.tri_val;
        color_in <= c.color_val;
        box_in <= c.box;
        subsample <= c.sub;
        valid_in <= 1'b1;
        // New width driven on the accept edge only reaches the next triangle
        @(posedge clk);
        valid_in <= 1'b0;
        subsample <= c.sub_after;
        wait_for_valid();
        exp_s = c.box.ll;
        last_s = sample_out;
        seen = 0;
        while (valid_out) begin
            seen++;
            check_true(seen <= c.count, "more valid samples than the box holds");
            check_fixed("sample x", exp_s.x, sample_out.x);
            check_fixed("sample y", exp_s.y, sample_out.y);
            check_tri(c.tri_val, tri_out);
            check_color(c.color_val, color_out);
            check_true(!halt_n, "halt_n high on a valid cycle");
            last_s = sample_out;
            // Model walk goes right along the row then wraps to the left edge
            if (exp_s.x >= c.box.ur.x) begin
                exp_s.x = c.box.ll.x;
                exp_s.y = exp_s.y + st;
            end else begin
                exp_s.x = exp_s.x + st;
            end
            // Scramble upstream data mid-walk
            random_triangle(junk_tri);
            random_color(junk_color);
            @(posedge clk);
            tri_in <= junk_tri;
            color_in <= junk_color;
            @(negedge clk);
        end
        check_int("sample count", c.count, seen);
        check_int("sample count by rule", count_from_rule(c.box, st), seen);
        check_fixed("last sample x", c.box.ur.x, last_s.x);
        check_fixed("last sample y", c.box.ur.y, last_s.y);
        wait_for_halt();
        check_true(!valid_out, "valid_out high while halt_n is high");
    endtask

    initial begin
        seed = 32'h44034678;
        cur_name = "reset";
        rst = 1'b1;
        tri_in = '0;
        color_in = '0;
        box_in = '0;
        valid_in = 1'b0;
        subsample = 4'b1000;
        load_cases();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_true(!valid_out && halt_n, "outputs not idle after reset");
        foreach (cases[i]) begin
            run_case(cases[i]);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test_iterator.sv ====
`timescale 1ns/1ps
`default_nettype none

module test_iterator
    import raster_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  triangle_t  tri_in,
    input  color_t     color_in,
    input  box_t       box_in,
    input  logic       valid_in,
    input  subsample_t subsample,
    output triangle_t  tri_out,
    output color_t     color_out,
    output point_t     sample_out,
    output logic       valid_out,
    output logic       halt_n
);

    // Controller to walker and step register
    logic   start;
    logic   advance;
    // Walker back to controller
    logic   at_end;
    // Step in force for this walk
    fixed_t step;

    iterator_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .tri_in    (tri_in),
        .color_in  (color_in),
        .at_end    (at_end),
        .start     (start),
        .advance   (advance),
        .tri_out   (tri_out),
        .color_out (color_out),
        .valid_out (valid_out),
        .halt_n    (halt_n)
    );

    box_walker u_walker (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .advance (advance),
        .box_in  (box_in),
        .step    (step),
        .sample  (sample_out),
        .at_end  (at_end)
    );

    msaa_step_reg u_step (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .subsample (subsample),
        .step      (step)
    );

endmodule

`default_nettype wire

// ==== iterator_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module iterator_ctrl
    import raster_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      valid_in,
    input  triangle_t tri_in,
    input  color_t    color_in,
    input  logic      at_end,
    output logic      start,
    output logic      advance,
    output triangle_t tri_out,
    output color_t    color_out,
    output logic      valid_out,
    output logic      halt_n
);

    iter_state_t state;
    iter_state_t next_state;

    // Accept pulse, inputs only matter while waiting
    assign start = (state == WAIT_STATE) && valid_in;

    // Keep stepping until the end-of-box sample is out
    assign advance = (state == TEST_STATE) && !at_end;

    always_comb begin
        next_state = state;
        case (state)
            WAIT_STATE: begin
                if (valid_in) begin
                    next_state = TEST_STATE;
                end
            end
            TEST_STATE: begin
                // Last sample of the box leaves this cycle
                if (at_end) begin
                    next_state = WAIT_STATE;
                end
            end
            default: next_state = WAIT_STATE;
        endcase
    end

    // State and its outputs move together
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= WAIT_STATE;
            valid_out <= 1'b0;
            // Upstream free to move out of reset
            halt_n <= 1'b1;
        end else begin
            state <= next_state;
            valid_out <= (next_state == TEST_STATE);
            halt_n <= (next_state != TEST_STATE);
        end
    end

    // Triangle and color held for the whole walk
    always_ff @(posedge clk) begin
        if (start) begin
            tri_out <= tri_in;
            color_out <= color_in;
        end
    end

    // Wait to test on a valid triangle
    a_wait_to_test: assert property (
        @(posedge clk) disable iff (rst)
        (state == WAIT_STATE) && valid_in |=> (state == TEST_STATE)
    );

    // Test to wait after the end-of-box sample
    a_test_to_wait: assert property (
        @(posedge clk) disable iff (rst)
        (state == TEST_STATE) && at_end |=> (state == WAIT_STATE)
    );

    // Idle input keeps us waiting
    a_wait_hold: assert property (
        @(posedge clk) disable iff (rst)
        (state == WAIT_STATE) && !valid_in |=> (state == WAIT_STATE)
    );

    // Mid-box keeps us testing
    a_test_hold: assert property (
        @(posedge clk) disable iff (rst)
        (state == TEST_STATE) && !at_end |=> (state == TEST_STATE)
    );

    // Upstream is halted exactly while samples are valid
    a_halt_vs_valid: assert property (
        @(posedge clk) disable iff (rst)
        valid_out == !halt_n
    );

endmodule

`default_nettype wire

// ==== box_walker.sv ====
`timescale 1ns/1ps
`default_nettype none

module box_walker
    import raster_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  logic   advance,
    input  box_t   box_in,
    input  fixed_t step,
    output point_t sample,
    output logic   at_end
);

    // Box being walked
    box_t box_q;

    // Candidate next samples
    point_t next_rt;
    point_t next_up;

    // Edge flags of the current sample
    logic at_right;
    logic at_top;

    // Step right on the same row
    always_comb begin
        next_rt = sample;
        next_rt.x = sample.x + step;
    end

    // Back to the left edge, one row up
    always_comb begin
        next_up.x = box_q.ll.x;
        next_up.y = sample.y + step;
    end

    // Signed compares since boxes may sit at negative coordinates
    // >= rather than == so a box off the step grid still terminates
    assign at_right = (sample.x >= box_q.ur.x);
    assign at_top = (sample.y >= box_q.ur.y);
    assign at_end = at_right && at_top;

    // Box latched on accept, sample steps on advance
    always_ff @(posedge clk) begin
        if (start) begin
            box_q <= box_in;
            // Walk begins at the lower-left corner
            sample <= box_in.ll;
        end else if (advance) begin
            if (at_right) begin
                sample <= next_up;
            end else begin
                sample <= next_rt;
            end
        end
    end

    // Every sample handed on mid-walk stays within the box in x
    a_sample_in_box_x: assert property (
        @(posedge clk) disable iff (rst)
        advance |-> (sample.x >= box_q.ll.x) && (sample.x <= box_q.ur.x)
    );

    // Same in y
    a_sample_in_box_y: assert property (
        @(posedge clk) disable iff (rst)
        advance |-> (sample.y >= box_q.ll.y) && (sample.y <= box_q.ur.y)
    );

endmodule

`default_nettype wire

// ==== msaa_step_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module msaa_step_reg
    import raster_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  subsample_t subsample,
    output fixed_t     step
);

    // Width in force for the current walk
    subsample_t sub_q;

    // Sampled only when a triangle is taken, so a mid-walk change waits
    // for the next triangle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // One pixel per step out of reset
            sub_q <= SS_1X;
        end else if (start) begin
            sub_q <= subsample;
        end
    end

    // One-hot code times 2^STEP_SHIFT
    // 1000 -> 1.0, 0100 -> 0.5, 0010 -> 0.25, 0001 -> 0.125
    assign step = fixed_t'(sub_q) << STEP_SHIFT;

    // Upstream must present a legal width whenever the controller accepts
    a_subsample_onehot: assert property (
        @(posedge clk) disable iff (rst)
        start |-> $onehot(subsample)
    );

endmodule

`default_nettype wire

// ==== raster_pkg.sv ====
`default_nettype none

package raster_pkg;

    // Signed fixed point, RADIX fraction bits below the integer part
    localparam int SIGFIG = 24;
    localparam int RADIX = 10;

    // Triangle geometry
    localparam int VERTS = 3;
    localparam int AXIS = 3;
    localparam int COLORS = 3;

    // Code 1000 shifted by this lands on exactly one pixel
    localparam int STEP_SHIFT = RADIX - 3;

    typedef logic signed [SIGFIG-1:0] fixed_t;
    typedef logic [SIGFIG-1:0] ucolor_t;

    // One vertex, x in the top bits
    typedef struct packed {
        fixed_t x;
        fixed_t y;
        fixed_t z;
    } vertex_t;

    typedef vertex_t [VERTS-1:0] triangle_t;
    typedef ucolor_t [COLORS-1:0] color_t;

    // Sample location or box corner
    typedef struct packed {
        fixed_t x;
        fixed_t y;
    } point_t;

    // Lower-left and upper-right corners
    typedef struct packed {
        point_t ll;
        point_t ur;
    } box_t;

    // One-hot MSAA sub-sample width
    typedef logic [3:0] subsample_t;

    localparam subsample_t SS_1X = 4'b1000;
    localparam subsample_t SS_4X = 4'b0100;
    localparam subsample_t SS_16X = 4'b0010;
    localparam subsample_t SS_64X = 4'b0001;

    typedef enum logic {
        WAIT_STATE,
        TEST_STATE
    } iter_state_t;

endpackage

`default_nettype wire
